// ==== hw/rv_settings.svh ====
// RV32I subset constants only; opcodes and funct codes outside the kept set are not listed
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// major opcodes
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_SYSTEM   7'b1110011

// funct3 of the kept alu operations
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F7_SUB      7'b0100000  // only funct7 that changes the op

// halt on ecall when a7 holds the exit code
`define ECALL_REG   5'd17
`define HALT_CODE   32'd10

`endif

// ==== hw/rv_pkg.sv ====
// instruction word views and alu op codes; no B, U or J formats since branches and jumps are absent
`include "rv_settings.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  // store immediate is split around the rd slot
  typedef struct packed {
    logic [6:0]             imm_hi;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_lo;
    logic [6:0]             opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } inst_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

endpackage

// ==== hw/reg_file.sv ====
// x0 reads zero; a write in the same cycle as a read of that register is returned by the read
`include "rv_settings.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic [`REG_ADDR_W-1:0] rd_addr,
  input  logic [`XLEN-1:0]       rd_data,
  input  logic                   rd_we
);

  logic [`XLEN-1:0] regs [1:31];  // no storage behind x0

  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    else if (rd_we && addr == rd_addr)
      return rd_data;  // write-through
    else
      return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

// ==== hw/fetch_stage.sv ====
// instruction memory must answer inst_addr combinationally in the same cycle; no branch redirect
`include "rv_settings.svh"

module fetch_stage import rv_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             mem_busy,
  input  logic             halt_req,
  output logic [`XLEN-1:0] inst_addr,
  input  logic [`XLEN-1:0] inst_data,
  output inst_u            if_inst,
  output logic             if_valid
);

  logic [`XLEN-1:0] pc;
  logic             hold;

  assign hold      = stall | mem_busy | halt_req;
  assign inst_addr = pc;

  always_ff @(posedge clk) begin
    if (reset)
      pc <= '0;
    else if (!hold)
      pc <= pc + `XLEN'd4;
  end

  // halt_req is sticky, so the kill lasts until reset
  always_ff @(posedge clk) begin
    if (reset)
      if_valid <= 1'b0;
    else if (!mem_busy) begin
      if (halt_req)
        if_valid <= 1'b0;
      else if (!stall)
        if_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold)
      if_inst <= inst_data;
  end

endmodule

// ==== hw/decode_stage.sv ====
// unknown opcodes pass as nops; ecall reads a7 through the rs1 port so it can be forwarded
`include "rv_settings.svh"

module decode_stage import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  inst_u                  if_inst,
  input  logic                   if_valid,
  input  logic                   mem_busy,
  input  logic                   halt_req,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  output logic                   stall,
  output logic [`REG_ADDR_W-1:0] ex_rs1,
  output logic [`REG_ADDR_W-1:0] ex_rs2,
  output logic [`REG_ADDR_W-1:0] ex_rd,
  output logic [`XLEN-1:0]       ex_a,
  output logic [`XLEN-1:0]       ex_b,
  output logic [`XLEN-1:0]       ex_imm,
  output alu_op_e                ex_op,
  output logic                   ex_use_imm,
  output logic                   ex_load,
  output logic                   ex_store,
  output logic                   ex_wen,
  output logic                   ex_ecall,
  output logic                   ex_valid
);

  logic [6:0]       opcode;
  logic             is_reg, is_imm, is_load, is_store, is_ecall;
  logic             uses_rs1, uses_rs2, writes_rd;
  logic             take;
  logic [`XLEN-1:0] imm;
  alu_op_e          op;

  assign opcode   = if_inst.r_fmt.opcode;
  assign is_reg   = opcode == `OP_REG;
  assign is_imm   = opcode == `OP_IMM;
  assign is_load  = opcode == `OP_LOAD;
  assign is_store = opcode == `OP_STORE;
  assign is_ecall = opcode == `OP_SYSTEM;

  assign uses_rs1  = is_reg | is_imm | is_load | is_store | is_ecall;
  assign uses_rs2  = is_reg | is_store;
  assign writes_rd = is_reg | is_imm | is_load;

  assign rs1_addr = is_ecall ? `ECALL_REG : if_inst.r_fmt.rs1;
  assign rs2_addr = if_inst.r_fmt.rs2;

  assign imm = is_store ?
      {{20{if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_hi, if_inst.s_fmt.imm_lo} :
      {{20{if_inst.i_fmt.imm12[11]}}, if_inst.i_fmt.imm12};

  always_comb begin
    op = ALU_ADD;  // address add for lw/sw
    if (is_reg || is_imm) begin
      case (if_inst.r_fmt.funct3)
        `F3_ADD: op = (is_reg && if_inst.r_fmt.funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
        `F3_SLL: op = ALU_SLL;
        `F3_XOR: op = ALU_XOR;
        `F3_SRL: op = ALU_SRL;
        `F3_OR:  op = ALU_OR;
        `F3_AND: op = ALU_AND;
        default: op = ALU_ADD;
      endcase
    end
  end

  // load result not ready until it reaches MEM/WB
  assign stall = if_valid && ex_valid && ex_load && ex_rd != '0 &&
                 ((uses_rs1 && rs1_addr == ex_rd) || (uses_rs2 && rs2_addr == ex_rd));

  assign take = if_valid & ~stall & ~halt_req;  // otherwise a bubble

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_wen   <= 1'b0;
      ex_load  <= 1'b0;
      ex_store <= 1'b0;
      ex_ecall <= 1'b0;
    end else if (!mem_busy) begin
      ex_valid <= take;
      ex_wen   <= take & writes_rd;
      ex_load  <= take & is_load;
      ex_store <= take & is_store;
      ex_ecall <= take & is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_busy) begin
      ex_rs1     <= rs1_addr;
      ex_rs2     <= rs2_addr;
      ex_rd      <= if_inst.r_fmt.rd;
      ex_a       <= rs1_data;
      ex_b       <= rs2_data;
      ex_imm     <= imm;
      ex_op      <= op;
      ex_use_imm <= is_imm | is_load | is_store;
    end
  end

endmodule

// ==== hw/execute_stage.sv ====
// two forwarding sources only; older values come from the write-through register file
`include "rv_settings.svh"

module execute_stage import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mem_busy,
  input  logic [`REG_ADDR_W-1:0] ex_rs1,
  input  logic [`REG_ADDR_W-1:0] ex_rs2,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  logic [`XLEN-1:0]       ex_a,
  input  logic [`XLEN-1:0]       ex_b,
  input  logic [`XLEN-1:0]       ex_imm,
  input  alu_op_e                ex_op,
  input  logic                   ex_use_imm,
  input  logic                   ex_load,
  input  logic                   ex_store,
  input  logic                   ex_wen,
  input  logic                   ex_ecall,
  input  logic                   ex_valid,
  input  logic [`REG_ADDR_W-1:0] mem_rd,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       mem_fwd,
  input  logic [`XLEN-1:0]       wb_fwd,
  input  logic                   mem_wen,
  input  logic                   wb_wen,
  output logic                   halt_req,
  output logic [`XLEN-1:0]       m_alu,
  output logic [`XLEN-1:0]       m_store_data,
  output logic [`REG_ADDR_W-1:0] m_rd,
  output logic                   m_load,
  output logic                   m_store,
  output logic                   m_wen,
  output logic                   m_valid
);

  logic [`XLEN-1:0] fwd_a, fwd_b, op_b, result;
  logic             halt_hit, halt_seen;

  // nearest older writer wins
  function automatic logic [`XLEN-1:0] pick_operand(input logic [`REG_ADDR_W-1:0] rs,
                                                    input logic [`XLEN-1:0] reg_val);
    if (mem_wen && mem_rd != '0 && mem_rd == rs)
      return mem_fwd;
    else if (wb_wen && wb_rd != '0 && wb_rd == rs)
      return wb_fwd;
    else
      return reg_val;
  endfunction

  always_comb begin
    fwd_a = pick_operand(ex_rs1, ex_a);
    fwd_b = pick_operand(ex_rs2, ex_b);
    op_b  = ex_use_imm ? ex_imm : fwd_b;
    case (ex_op)
      ALU_SUB: result = fwd_a - op_b;
      ALU_AND: result = fwd_a & op_b;
      ALU_OR:  result = fwd_a | op_b;
      ALU_XOR: result = fwd_a ^ op_b;
      ALU_SLL: result = fwd_a << op_b[4:0];
      ALU_SRL: result = fwd_a >> op_b[4:0];
      default: result = fwd_a + op_b;
    endcase
  end

  // a7 arrives on operand a for ecall
  assign halt_hit = ex_valid & ex_ecall & (fwd_a == `HALT_CODE);
  assign halt_req = halt_hit | halt_seen;

  always_ff @(posedge clk) begin
    if (reset)
      halt_seen <= 1'b0;
    else if (halt_hit)
      halt_seen <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid <= 1'b0;
      m_wen   <= 1'b0;
      m_load  <= 1'b0;
      m_store <= 1'b0;
    end else if (!mem_busy) begin
      m_valid <= ex_valid;
      m_wen   <= ex_wen;
      m_load  <= ex_load;
      m_store <= ex_store;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_busy) begin
      m_alu        <= result;
      m_store_data <= fwd_b;  // rs2 after forwarding
      m_rd         <= ex_rd;
    end
  end

endmodule

// ==== hw/result_stage.sv ====
// word accesses only on a Wishbone classic master; the pipeline freezes until ack
`include "rv_settings.svh"

module result_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       m_alu,
  input  logic [`XLEN-1:0]       m_store_data,
  input  logic [`REG_ADDR_W-1:0] m_rd,
  input  logic                   m_load,
  input  logic                   m_store,
  input  logic                   m_wen,
  input  logic                   m_valid,
  input  logic                   halt_req,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`XLEN-1:0]       wb_adr,
  output logic [`XLEN-1:0]       wb_dat_w,
  input  logic [`XLEN-1:0]       wb_dat_r,
  input  logic                   wb_ack,
  output logic                   mem_busy,
  output logic [`XLEN-1:0]       mem_fwd,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data,
  output logic                   wb_wen,
  output logic                   is_halted
);

  logic need_access;
  logic wb_valid;

  assign need_access = m_valid & (m_load | m_store);
  // the ack cycle lets the pipeline move, so the access is not repeated
  assign mem_busy    = need_access & ~(wb_cyc & wb_ack);

  // EX/MEM is frozen during the access, so these hold steady
  assign wb_stb   = wb_cyc;
  assign wb_we    = m_store;
  assign wb_adr   = m_alu;
  assign wb_dat_w = m_store_data;
  assign mem_fwd  = m_alu;

  always_ff @(posedge clk) begin
    if (reset)
      wb_cyc <= 1'b0;
    else if (wb_cyc) begin
      if (wb_ack)
        wb_cyc <= 1'b0;  // drops the cycle after ack
    end else if (need_access) begin
      wb_cyc <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_wen   <= 1'b0;
    end else if (!mem_busy) begin
      wb_valid <= m_valid;
      wb_wen   <= m_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_busy) begin
      wb_rd   <= m_rd;
      wb_data <= m_load ? wb_dat_r : m_alu;
    end
  end

  // wait for older instructions to drain
  always_ff @(posedge clk) begin
    if (reset)
      is_halted <= 1'b0;
    else if (halt_req && !m_valid && !wb_valid)
      is_halted <= 1'b1;
  end

endmodule

// ==== hw/rv_core.sv ====
// five-stage RV32I subset core; no branches or jumps, halts for good on ecall with a7 == 10
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] inst_addr,
  input  logic [`XLEN-1:0] inst_data,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [`XLEN-1:0] wb_adr,
  output logic [`XLEN-1:0] wb_dat_w,
  input  logic [`XLEN-1:0] wb_dat_r,
  input  logic             wb_ack,
  output logic             is_halted
);

  inst_u                  if_inst;
  logic                   if_valid, stall, halt_req, mem_busy;
  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [`XLEN-1:0]       rs1_data, rs2_data;
  logic [`REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [`XLEN-1:0]       ex_a, ex_b, ex_imm;
  alu_op_e                ex_op;
  logic                   ex_use_imm, ex_load, ex_store, ex_wen, ex_ecall, ex_valid;
  logic [`XLEN-1:0]       m_alu, m_store_data, mem_fwd;
  logic [`REG_ADDR_W-1:0] m_rd, wb_rd;
  logic                   m_load, m_store, m_wen, m_valid;
  logic [`XLEN-1:0]       wb_data;
  logic                   wb_wen;

  fetch_stage fetch_i (
    .clk, .reset, .stall, .mem_busy, .halt_req,
    .inst_addr, .inst_data, .if_inst, .if_valid
  );

  decode_stage decode_i (
    .clk, .reset, .if_inst, .if_valid, .mem_busy, .halt_req,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .stall,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_op,
    .ex_use_imm, .ex_load, .ex_store, .ex_wen, .ex_ecall, .ex_valid
  );

  execute_stage execute_i (
    .clk, .reset, .mem_busy,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_op,
    .ex_use_imm, .ex_load, .ex_store, .ex_wen, .ex_ecall, .ex_valid,
    .mem_rd(m_rd), .wb_rd, .mem_fwd, .wb_fwd(wb_data), .mem_wen(m_wen), .wb_wen,
    .halt_req, .m_alu, .m_store_data, .m_rd, .m_load, .m_store, .m_wen, .m_valid
  );

  result_stage result_i (
    .clk, .reset, .m_alu, .m_store_data, .m_rd, .m_load, .m_store, .m_wen, .m_valid,
    .halt_req, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .mem_busy, .mem_fwd, .wb_rd, .wb_data, .wb_wen, .is_halted
  );

  reg_file reg_file_i (
    .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .rd_addr(wb_rd), .rd_data(wb_data), .rd_we(wb_wen)
  );

endmodule

// ==== bench/core_checker.sv ====
// acked writes are compared in order with the table; reads are only checked for lateness
module core_checker #(
  parameter int N_EXP = 1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_ack,
  input  logic [31:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        is_halted,
  input  logic [63:0] expected [N_EXP],
  output int          value_errors,
  output int          extra_accesses,
  output int          stores_seen,
  output int          halt_drops
);

  logic halted_before;
  int   bad;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("** Error @ %0t: %s expected %h, actual %h", $time, name, exp_val, act_val);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      value_errors   <= 0;
      extra_accesses <= 0;
      stores_seen    <= 0;
      halt_drops     <= 0;
      halted_before  <= 1'b0;
    end else begin
      bad = 0;
      if (wb_stb !== wb_cyc) begin  // stb rises and drops with cyc
        report_mismatch("wb_stb", 32'(wb_cyc), 32'(wb_stb));
        bad++;
      end
      if (wb_cyc && wb_stb && wb_ack) begin
        if (stores_seen >= N_EXP) begin
          $display("unexpected Wishbone %s at address %h after the last expected store",
                   wb_we ? "write" : "read", wb_adr);
          extra_accesses <= extra_accesses + 1;
        end else if (wb_we) begin
          if (wb_adr !== expected[stores_seen][63:32]) begin
            report_mismatch("wb_adr", expected[stores_seen][63:32], wb_adr);
            bad++;
          end
          if (wb_dat_w !== expected[stores_seen][31:0]) begin
            report_mismatch("wb_dat_w", expected[stores_seen][31:0], wb_dat_w);
            bad++;
          end
          stores_seen <= stores_seen + 1;
        end
      end
      value_errors <= value_errors + bad;
      if (halted_before && !is_halted) begin
        $display("is_halted dropped after it had risen");  // halt must hold until reset
        halt_drops <= halt_drops + 1;
      end
      halted_before <= is_halted;
    end
  end

endmodule

// ==== bench/core_tb.sv ====
// hand-encoded program on rv_core; memory answers after 0 to 3 extra cycles, fixed seed
`include "rv_settings.svh"

module core_tb;

  localparam int N_EXP        = 15;
  localparam int HALT_TIMEOUT = 1000;
  localparam int QUIET_CYCLES = 20;
  localparam int F3_WORD      = 2;  // funct3 of lw and sw

  logic        clk;
  logic        reset;
  logic [31:0] inst_addr;
  logic [31:0] inst_data;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
  logic        is_halted;

  logic [31:0] prog [$];
  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [63:0] expected [N_EXP];  // {address, data} of each store in program order
  logic [1:0]  wait_left;
  integer      seed;
  int          value_errors, extra_accesses, stores_seen, halt_drops;
  int          cycles, missing, halt_timeouts;

  rv_core dut_i (
    .clk, .reset, .inst_addr, .inst_data,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .is_halted
  );

  core_checker #(.N_EXP(N_EXP)) checker_i (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_ack, .wb_adr, .wb_dat_w, .is_halted,
    .expected, .value_errors, .extra_accesses, .stores_seen, .halt_drops
  );

  // field packing straight from the RV32I formats
  function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input int op, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'(F3_WORD), imm[4:0], `OP_STORE};
  endfunction

  task automatic build_program();
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 1, 0, 'h5a3));  // addi x1, x0, 0x5a3
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 2, 0, -240));   // x2 = 0xffffff10
    prog.push_back(r_type(0, `F3_ADD, 3, 1, 2));            // distance 1 and 2
    prog.push_back(r_type(`F7_SUB, `F3_ADD, 4, 1, 2));
    prog.push_back(r_type(0, `F3_AND, 5, 1, 2));
    prog.push_back(r_type(0, `F3_OR, 6, 1, 2));
    prog.push_back(r_type(0, `F3_XOR, 7, 1, 2));
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 8, 0, 36));     // shift amount 36, low bits 4
    prog.push_back(r_type(0, `F3_SLL, 9, 1, 8));
    prog.push_back(r_type(0, `F3_SRL, 10, 2, 8));
    prog.push_back(s_type(3, 0, 'h80));
    prog.push_back(s_type(4, 0, 'h84));
    prog.push_back(s_type(5, 0, 'h88));
    prog.push_back(s_type(6, 0, 'h8c));
    prog.push_back(s_type(7, 0, 'h90));
    prog.push_back(s_type(9, 0, 'h94));
    prog.push_back(s_type(10, 0, 'h98));
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 11, 1, -3));
    prog.push_back(i_type(`OP_IMM, `F3_AND, 12, 2, -256));
    prog.push_back(i_type(`OP_IMM, `F3_OR, 13, 1, -2048));
    prog.push_back(i_type(`OP_IMM, `F3_XOR, 14, 1, -1));
    prog.push_back(i_type(`OP_IMM, `F3_SLL, 15, 2, 8));     // slli
    prog.push_back(i_type(`OP_IMM, `F3_SRL, 16, 2, 28));    // srli
    for (int r = 11; r <= 16; r++)
      prog.push_back(s_type(r, 0, 'h9c + 4 * (r - 11)));     // x11..x16 to 0x9c..0xb0
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 0, 1, 5));      // write to x0 is dropped
    prog.push_back(r_type(0, `F3_ADD, 18, 0, 1));
    prog.push_back(s_type(18, 0, 'hb4));
    prog.push_back(i_type(`OP_LOAD, F3_WORD, 19, 0, 'h40)); // lw x19, 0x40(x0)
    prog.push_back(r_type(0, `F3_ADD, 20, 19, 1));          // load-use stall
    prog.push_back(s_type(20, 0, 'hb8));
    prog.push_back(i_type(`OP_IMM, `F3_ADD, 17, 0, 10));    // a7 = 10
    prog.push_back(i_type(`OP_SYSTEM, 0, 0, 0, 0));         // ecall
    prog.push_back(s_type(1, 0, 'hbc));                     // must never reach memory
  endtask

  task automatic build_expected();
    expected[0]  = {32'h80, 32'h0000_04b3};
    expected[1]  = {32'h84, 32'h0000_0693};
    expected[2]  = {32'h88, 32'h0000_0500};
    expected[3]  = {32'h8c, 32'hffff_ffb3};
    expected[4]  = {32'h90, 32'hffff_fab3};
    expected[5]  = {32'h94, 32'h0000_5a30};
    expected[6]  = {32'h98, 32'h0fff_fff1};
    expected[7]  = {32'h9c, 32'h0000_05a0};
    expected[8]  = {32'ha0, 32'hffff_ff00};
    expected[9]  = {32'ha4, 32'hffff_fda3};
    expected[10] = {32'ha8, 32'hffff_fa5c};
    expected[11] = {32'hac, 32'hffff_1000};
    expected[12] = {32'hb0, 32'h0000_000f};
    expected[13] = {32'hb4, 32'h0000_05a3};
    expected[14] = {32'hb8, 32'h1234_5c1b};  // loaded word plus x1
  endtask

  always #5 clk = ~clk;

  assign inst_data = imem[inst_addr[7:2]];

  // registered ack, one access at a time
  always @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 2'd0) begin
        wb_ack <= 1'b1;
        if (wb_we)
          dmem[wb_adr[7:2]] <= wb_dat_w;
        else
          wb_dat_r <= dmem[wb_adr[7:2]];
        wait_left <= 2'($random(seed));  // delay of the next access
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    wb_ack        = 1'b0;
    wb_dat_r      = '0;
    seed          = 62;
    wait_left     = 2'($random(seed));
    halt_timeouts = 0;
    build_program();
    build_expected();
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;  // zero word decodes as a nop
      dmem[i] = 32'hd000_0000 | (i << 2);
    end
    dmem[16] = 32'h1234_5678;  // load source at 0x40
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (!is_halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!is_halted) begin
      $display("timeout: is_halted did not rise within %0d cycles", HALT_TIMEOUT);
      halt_timeouts = 1;
    end
    repeat (QUIET_CYCLES) @(negedge clk);  // late accesses would show up here
    missing = N_EXP - stores_seen;
    if (missing > 0)
      $display("%0d expected stores were never seen", missing);
    $display("errors: %0d value, %0d extra access, %0d missing store, %0d halt",
             value_errors, extra_accesses, missing, halt_timeouts + halt_drops);
    if (value_errors + extra_accesses + missing + halt_timeouts + halt_drops == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hw
hw/rv_pkg.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv_core.sv
bench/core_checker.sv
bench/core_tb.sv
